// ==== common/link_pkg.sv ====
/*
 * Link self-test package
 * Status and error codes, lane word format and the lane CRC-8
 */
package link_pkg;

   localparam int DATA_W = 64;

   typedef logic [DATA_W-1:0] data_t;

   // One-hot link status, ready matches the board LED decode
   typedef enum logic [3:0] {
      ST_RESET = 4'b0001,
      ST_TRAIN = 4'b0010,
      ST_READY = 4'b0100,
      ST_FAULT = 4'b1000
   } status_t;

   typedef enum logic [3:0] {
      EC_NONE  = 4'h0,
      EC_CRC   = 4'h1,
      EC_ALIGN = 4'h2
   } ecode_t;

   // Training and alignment pattern
   localparam data_t ALIGN_WORD = 64'hA55A_F00F_3CC3_0FF0;

   // Lane word, ctrl set for alignment words
   typedef struct packed {
      logic       ctrl;
      data_t      data;
      logic [7:0] crc;
   } lane_word_t;

   // CRC-8, polynomial 0x07, init 0, MSB first
   function automatic logic [7:0] crc8(input data_t data);
      logic [7:0] crc;
      logic       fb;
      crc = 8'h00;
      for (int i = DATA_W - 1; i >= 0; i--) begin
         fb  = crc[7] ^ data[i];
         crc = {crc[6:0], 1'b0};
         if (fb) begin
            crc = crc ^ 8'h07;
         end
      end
      return crc;
   endfunction

endpackage

// ==== source/reset_sequencer.sv ====
/*
 * Reset sequencer
 * Synchronizes the board reset and stretches it by 16 cycles
 */
module reset_sequencer (
   input  logic FCLK,
   input  logic ARSTn,
   output logic link_rstn
);

   logic [1:0] rst_sync;
   logic       sync_rstn;
   logic [4:0] rst_cnt;

   // Two-flop synchronizer, asserts at once and releases on the clock
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         rst_sync <= 2'b00;
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   assign sync_rstn = rst_sync[1];

   // Count 16 cycles, top bit becomes the link reset
   always_ff @(posedge FCLK or negedge sync_rstn) begin
      if (!sync_rstn) begin
         rst_cnt <= 5'h00;
      end else if (!rst_cnt[4]) begin
         rst_cnt <= rst_cnt + 5'h01;
      end
   end

   assign link_rstn = rst_cnt[4];

endmodule

// ==== source/traffic_gen.sv ====
/*
 * Traffic generator
 * Streams an incrementing count under a valid/ready handshake
 */
module traffic_gen
   import link_pkg::*;
(
   input  logic  FCLK,
   input  logic  ARSTn,
   output data_t tx_data,
   output logic  tx_valid,
   input  logic  tx_ready
);

   logic word_accepted;

   assign word_accepted = tx_valid && tx_ready;

   // Valid from the first cycle out of reset
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= 1'b1;
      end
   end

   // Count moves on only when the PHY takes the word
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         tx_data <= '0;
      end else if (word_accepted) begin
         tx_data <= tx_data + data_t'(1);
      end
   end

endmodule

// ==== source/traffic_check.sv ====
/*
 * Traffic checker
 * Compares received words against a local count, sticky error flag
 */
module traffic_check
   import link_pkg::*;
(
   input  logic        FCLK,
   input  logic        ARSTn,
   input  data_t       rx_data,
   input  logic        rx_valid,
   output logic        data_error,
   output logic [31:0] rx_count
);

   data_t rx_ref;
   logic  mismatch;

   assign mismatch = rx_valid && (rx_data != rx_ref);

   // Reference count follows every valid word
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         rx_ref <= '0;
      end else if (rx_valid) begin
         rx_ref <= rx_ref + data_t'(1);
      end
   end

   // Error holds until the next reset
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         data_error <= 1'b0;
      end else if (mismatch) begin
         data_error <= 1'b1;
      end
   end

   // Received word count
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         rx_count <= 32'h0;
      end else if (rx_valid) begin
         rx_count <= rx_count + 32'h1;
      end
   end

endmodule

// ==== phy/phy_fifo.sv ====
/*
 * PHY transmit FIFO
 * Synchronous circular buffer with valid/ready on both sides
 */
module phy_fifo
   import link_pkg::*;
#(
   parameter int DEPTH = 8
) (
   input  logic  FCLK,
   input  logic  ARSTn,
   input  data_t wr_data,
   input  logic  wr_valid,
   output logic  wr_ready,
   output data_t rd_data,
   output logic  rd_valid,
   input  logic  rd_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   data_t             mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              do_wr;
   logic              do_rd;

   assign wr_ready = (count != CNT_W'(DEPTH));
   assign rd_valid = (count != '0);
   assign do_wr    = wr_valid && wr_ready;
   assign do_rd    = rd_valid && rd_ready;
   assign rd_data  = mem[rd_ptr];

   always_ff @(posedge FCLK) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers wrap explicitly so any depth works
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         count <= '0;
      end else begin
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== phy/phy_link.sv ====
/*
 * PHY link engine
 * Training, alignment insertion, CRC framing and a fixed-delay loopback lane
 */
module phy_link
   import link_pkg::*;
#(
   parameter int LANE_DELAY   = 4,
   parameter int TRAIN_WORDS  = 8,
   parameter int ALIGN_PERIOD = 32
) (
   input  logic    FCLK,
   input  logic    ARSTn,
   input  data_t   word_data,
   input  logic    word_valid,
   output logic    word_ready,
   input  logic    err_inject,
   output data_t   rx_data,
   output logic    rx_valid,
   output status_t status,
   output ecode_t  ecode
);

   localparam int TCNT_W = $clog2(TRAIN_WORDS + 1);
   localparam int PCNT_W = $clog2(ALIGN_PERIOD + 1);

   logic [TCNT_W-1:0]     train_cnt;
   logic [PCNT_W-1:0]     period_cnt;
   logic                  align_due;
   logic                  word_pop;
   logic                  launch_valid;
   data_t                 launch_data;
   lane_word_t            launch_word;
   lane_word_t            lane_q [LANE_DELAY];
   logic [LANE_DELAY-1:0] lane_vld;
   lane_word_t            lane_out;
   logic                  lane_out_vld;
   logic                  crc_ok;
   logic                  align_ok;
   logic                  data_ok;

   // An alignment word is due after ALIGN_PERIOD data words
   assign align_due  = (period_cnt == PCNT_W'(ALIGN_PERIOD));
   assign word_ready = (status == ST_READY) && !align_due;
   assign word_pop   = word_valid && word_ready;

   // Anything not carrying data goes out as an alignment word
   assign launch_valid = (status == ST_TRAIN) || (status == ST_READY);
   assign launch_data  = word_pop ? word_data : ALIGN_WORD;
   assign launch_word  = '{ctrl: !word_pop,
                           data: launch_data ^ data_t'(err_inject),
                           crc:  crc8(launch_data)};

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         period_cnt <= '0;
      end else begin
         period_cnt <= word_pop ? period_cnt + 1'b1 : '0;
      end
   end

   // Loopback lane
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         lane_vld <= '0;
      end else begin
         lane_vld[0] <= launch_valid;
         for (int i = 1; i < LANE_DELAY; i++) begin
            lane_vld[i] <= lane_vld[i-1];
         end
      end
   end

   always_ff @(posedge FCLK) begin
      lane_q[0] <= launch_word;
      for (int i = 1; i < LANE_DELAY; i++) begin
         lane_q[i] <= lane_q[i-1];
      end
   end

   // Receive decode
   assign lane_out     = lane_q[LANE_DELAY-1];
   assign lane_out_vld = lane_vld[LANE_DELAY-1];
   assign crc_ok       = (crc8(lane_out.data) == lane_out.crc);
   assign align_ok     = crc_ok && lane_out.ctrl && (lane_out.data == ALIGN_WORD);
   assign data_ok      = crc_ok && !lane_out.ctrl;

   // Status FSM, training counter and error latch
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         status    <= ST_RESET;
         ecode     <= EC_NONE;
         train_cnt <= '0;
         rx_valid  <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (status)
            ST_RESET: status <= ST_TRAIN;
            ST_TRAIN: begin
               if (lane_out_vld) begin
                  if (!align_ok) begin
                     train_cnt <= '0;
                  end else if (train_cnt == TCNT_W'(TRAIN_WORDS - 1)) begin
                     train_cnt <= '0;
                     status    <= ST_READY;
                  end else begin
                     train_cnt <= train_cnt + 1'b1;
                  end
               end
            end
            ST_READY: begin
               if (lane_out_vld) begin
                  if (!crc_ok) begin
                     status <= ST_FAULT;
                     ecode  <= EC_CRC;
                  end else if (lane_out.ctrl && !align_ok) begin
                     status <= ST_FAULT;
                     ecode  <= EC_ALIGN;
                  end else begin
                     rx_valid <= data_ok;
                  end
               end
            end
            // Fault holds until reset
            default: status <= ST_FAULT;
         endcase
      end
   end

   always_ff @(posedge FCLK) begin
      if (lane_out_vld && data_ok) begin
         rx_data <= lane_out.data;
      end
   end

endmodule

// ==== phy/phy_top.sv ====
/*
 * PHY model
 * Transmit FIFO in front of the link engine
 */
module phy_top
   import link_pkg::*;
#(
   parameter int FIFO_DEPTH   = 8,
   parameter int LANE_DELAY   = 4,
   parameter int TRAIN_WORDS  = 8,
   parameter int ALIGN_PERIOD = 32
) (
   input  logic    FCLK,
   input  logic    ARSTn,
   input  data_t   tx_data,
   input  logic    tx_valid,
   output logic    tx_ready,
   input  logic    err_inject,
   output data_t   rx_data,
   output logic    rx_valid,
   output status_t status,
   output ecode_t  ecode
);

   logic  link_up;
   logic  fifo_wr_ready;
   data_t word_data;
   logic  word_valid;
   logic  word_ready;

   // Upstream stalls for good once the link faults
   assign link_up  = (status == ST_TRAIN) || (status == ST_READY);
   assign tx_ready = fifo_wr_ready && link_up;

   phy_fifo #(
      .DEPTH(FIFO_DEPTH)
   ) fifo_inst (
      .FCLK    (FCLK),
      .ARSTn   (ARSTn),
      .wr_data (tx_data),
      .wr_valid(tx_valid && link_up),
      .wr_ready(fifo_wr_ready),
      .rd_data (word_data),
      .rd_valid(word_valid),
      .rd_ready(word_ready)
   );

   phy_link #(
      .LANE_DELAY  (LANE_DELAY),
      .TRAIN_WORDS (TRAIN_WORDS),
      .ALIGN_PERIOD(ALIGN_PERIOD)
   ) link_inst (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .word_data (word_data),
      .word_valid(word_valid),
      .word_ready(word_ready),
      .err_inject(err_inject),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid),
      .status    (status),
      .ecode     (ecode)
   );

endmodule

// ==== source/link_test_top.sv ====
/*
 * Link self-test top level
 * Reset sequencer, traffic generator, PHY model, checker and status LEDs
 */
module link_test_top
   import link_pkg::*;
#(
   parameter int FIFO_DEPTH   = 8,
   parameter int LANE_DELAY   = 4,
   parameter int TRAIN_WORDS  = 8,
   parameter int ALIGN_PERIOD = 32
) (
   input  logic        FCLK,
   input  logic        ARSTn,
   input  logic        err_inject,
   output data_t       rx_data,
   output logic        rx_valid,
   output logic        tx_ready,
   output status_t     status,
   output ecode_t      ecode,
   output logic [31:0] rx_count,
   output logic [2:0]  led
);

   logic  link_rstn;
   data_t tx_data;
   logic  tx_valid;
   logic  data_error;

   reset_sequencer reset_sequencer_inst (
      .FCLK     (FCLK),
      .ARSTn    (ARSTn),
      .link_rstn(link_rstn)
   );

   traffic_gen traffic_gen_inst (
      .FCLK    (FCLK),
      .ARSTn   (link_rstn),
      .tx_data (tx_data),
      .tx_valid(tx_valid),
      .tx_ready(tx_ready)
   );

   phy_top #(
      .FIFO_DEPTH  (FIFO_DEPTH),
      .LANE_DELAY  (LANE_DELAY),
      .TRAIN_WORDS (TRAIN_WORDS),
      .ALIGN_PERIOD(ALIGN_PERIOD)
   ) phy_top_inst (
      .FCLK      (FCLK),
      .ARSTn     (link_rstn),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_ready  (tx_ready),
      .err_inject(err_inject),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid),
      .status    (status),
      .ecode     (ecode)
   );

   // Receive side is always ready, no back-pressure here
   traffic_check traffic_check_inst (
      .FCLK      (FCLK),
      .ARSTn     (link_rstn),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid),
      .data_error(data_error),
      .rx_count  (rx_count)
   );

   // Board LEDs
   assign led[0] = (status == ST_READY);
   assign led[1] = (ecode == EC_NONE);
   assign led[2] = ~data_error;

endmodule

// ==== bench/link_test_props.sv ====
/*
 * PHY handshake and status properties, bound into phy_top
 */
module link_test_props
   import link_pkg::*;
(
   input logic    FCLK,
   input logic    ARSTn,
   input data_t   tx_data,
   input logic    tx_valid,
   input logic    tx_ready,
   input logic    rx_valid,
   input status_t status
);
   timeunit 1ns;
   timeprecision 1ps;

   // Sticky failure flags, one per property
   logic hold_failed        = 1'b0;
   logic rx_status_failed   = 1'b0;
   logic onehot_failed      = 1'b0;
   logic fault_ready_failed = 1'b0;

   // A stalled word stays on the bus unchanged
   tx_hold: assert property (@(posedge FCLK) disable iff (!ARSTn)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
      else begin
         hold_failed = 1'b1;
         $error("tx_valid dropped or tx_data changed during a stall");
      end

   rx_only_ready: assert property (@(posedge FCLK) disable iff (!ARSTn)
      rx_valid |-> status == ST_READY)
      else begin
         rx_status_failed = 1'b1;
         $error("rx_valid high outside ST_READY, status 0x%h", status);
      end

   status_onehot: assert property (@(posedge FCLK) disable iff (!ARSTn)
      $onehot(status))
      else begin
         onehot_failed = 1'b1;
         $error("status 0x%h is not one-hot", status);
      end

   // Upstream must see a permanent stall once faulted
   fault_stall: assert property (@(posedge FCLK) disable iff (!ARSTn)
      status == ST_FAULT |-> !tx_ready)
      else begin
         fault_ready_failed = 1'b1;
         $error("tx_ready high in ST_FAULT");
      end

endmodule

// ==== bench/link_test_tb.sv ====
/*
 * Link self-test testbench
 * Drives reset and error injection and checks the received stream against a model
 */
module link_test_tb
   import link_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int FIFO_DEPTH   = 8;
   localparam int LANE_DELAY   = 4;
   localparam int TRAIN_WORDS  = 8;
   localparam int ALIGN_PERIOD = 32;

   localparam int RESET_CYCLES  = 5;
   localparam int READY_LIMIT   = 18 + TRAIN_WORDS + 2 * LANE_DELAY + 10;
   localparam int STREAM_WORDS  = 2000;
   // At most ALIGN_PERIOD data words run back to back between alignment words
   localparam int MIN_GAPS      = (STREAM_WORDS + ALIGN_PERIOD - 1) / ALIGN_PERIOD - 1;
   localparam int PULSE_MIN     = 20;
   localparam int PULSE_SPAN    = 200;
   localparam int FAULT_LIMIT   = LANE_DELAY + 4;
   localparam int FAULT_HOLD    = 64;
   localparam int RESTART_WORDS = 300;
   localparam int PLAN_WORDS    = STREAM_WORDS + PULSE_MIN + PULSE_SPAN + FAULT_HOLD
                                  + RESTART_WORDS;
   localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + READY_LIMIT) + 4 * PLAN_WORDS + 200;

   logic        FCLK;
   logic        ARSTn;
   logic        err_inject;
   data_t       rx_data;
   logic        rx_valid;
   logic        tx_ready;
   status_t     status;
   ecode_t      ecode;
   logic [31:0] rx_count;
   logic [2:0]  led;

   // Stream model
   data_t       expected_data;
   int unsigned seen_count;
   int unsigned gap_count;
   logic        expect_idle;

   integer      seed = 41;
   int          pulse_delay;
   int unsigned cycle_count = 0;
   logic        props_failed;

   link_test_top #(
      .FIFO_DEPTH  (FIFO_DEPTH),
      .LANE_DELAY  (LANE_DELAY),
      .TRAIN_WORDS (TRAIN_WORDS),
      .ALIGN_PERIOD(ALIGN_PERIOD)
   ) link_test_top_inst (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .err_inject(err_inject),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid),
      .tx_ready  (tx_ready),
      .status    (status),
      .ecode     (ecode),
      .rx_count  (rx_count),
      .led       (led)
   );

   bind phy_top link_test_props props_inst (
      .FCLK    (FCLK),
      .ARSTn   (ARSTn),
      .tx_data (tx_data),
      .tx_valid(tx_valid),
      .tx_ready(tx_ready),
      .rx_valid(rx_valid),
      .status  (status)
   );

   assign props_failed = link_test_top_inst.phy_top_inst.props_inst.hold_failed
                      || link_test_top_inst.phy_top_inst.props_inst.rx_status_failed
                      || link_test_top_inst.phy_top_inst.props_inst.onehot_failed
                      || link_test_top_inst.phy_top_inst.props_inst.fault_ready_failed;

   initial FCLK = 1'b0;
   always #4 FCLK = ~FCLK;

   always @(posedge FCLK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   always @(posedge props_failed) begin
      fail_run("a bound PHY assertion failed during the run");
   end

   task automatic fail_run(input string what);
      $display("[ERROR] %s", what);
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_data(input string name, input data_t actual, input data_t expected);
      if (actual !== expected) begin
         fail_run($sformatf("%s is 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic check_status(input status_t act_status, input ecode_t act_ecode,
                               input status_t exp_status, input ecode_t exp_ecode);
      if (act_status !== exp_status) begin
         fail_run($sformatf("status is 0x%h, expected 0x%h", act_status, exp_status));
      end
      if (act_ecode !== exp_ecode) begin
         fail_run($sformatf("ecode is 0x%h, expected 0x%h", act_ecode, exp_ecode));
      end
   endtask

   task automatic check_count(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         fail_run($sformatf("%s is 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic check_leds(input logic [2:0] actual, input logic [2:0] expected);
      if (actual !== expected) begin
         fail_run($sformatf("led is 0x%h, expected 0x%h", actual, expected));
      end
   endtask

   // Advance one clock and sample outputs at the falling edge
   task automatic next_cycle();
      @(negedge FCLK);
      // rx_count lags rx_valid by one cycle
      check_count("rx_count", rx_count, seen_count);
      if (rx_valid) begin
         if (expect_idle) begin
            fail_run("rx_valid went high after the link faulted");
         end
         check_data("rx_data", rx_data, expected_data);
         expected_data = expected_data + 64'd1;
         seen_count++;
      end else if (status == ST_READY && seen_count != 0) begin
         gap_count++;
      end
   endtask

   task automatic apply_reset();
      ARSTn         = 1'b0;
      expected_data = '0;
      seen_count    = 0;
      expect_idle   = 1'b0;
      repeat (RESET_CYCLES) begin
         next_cycle();
      end
      ARSTn = 1'b1;
   endtask

   task automatic wait_for_ready();
      int waited;
      waited = 0;
      while (status != ST_READY) begin
         if (waited >= READY_LIMIT) begin
            fail_run("link did not reach ST_READY within the training allowance");
         end
         next_cycle();
         waited++;
      end
      check_status(status, ecode, ST_READY, EC_NONE);
      check_leds(led, 3'b111);
   endtask

   task automatic wait_for_fault();
      int waited;
      waited = 0;
      while (status != ST_FAULT) begin
         if (waited >= FAULT_LIMIT) begin
            fail_run("link did not enter ST_FAULT after the error injection pulse");
         end
         next_cycle();
         waited++;
      end
      check_status(status, ecode, ST_FAULT, EC_CRC);
      check_leds(led, 3'b100);
   endtask

   task automatic run_words(input int unsigned target);
      while (seen_count < target) begin
         next_cycle();
         check_status(status, ecode, ST_READY, EC_NONE);
         check_leds(led, 3'b111);
      end
   endtask

   initial begin
      err_inject  = 1'b0;
      gap_count   = 0;
      pulse_delay = 0;
      apply_reset();
      wait_for_ready();

      // Clean stream where alignment words show up as gaps
      gap_count = 0;
      run_words(STREAM_WORDS);
      if (gap_count < MIN_GAPS) begin
         fail_run($sformatf("only %0d gaps in rx_valid, alignment insertion needs at least %0d",
                            gap_count, MIN_GAPS));
      end

      // Single injected bit error at a random point in the stream
      pulse_delay = PULSE_MIN + int'($unsigned($random(seed)) % PULSE_SPAN);
      run_words(seen_count + pulse_delay);
      err_inject = 1'b1;
      next_cycle();
      err_inject = 1'b0;
      wait_for_fault();
      expect_idle = 1'b1;
      repeat (FAULT_HOLD) begin
         next_cycle();
         check_status(status, ecode, ST_FAULT, EC_CRC);
         check_leds(led, 3'b100);
         if (tx_ready) begin
            fail_run("tx_ready went high while the link was in ST_FAULT");
         end
      end

      // Recovery restarts the stream and the count from zero
      apply_reset();
      wait_for_ready();
      run_words(RESTART_WORDS);

      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== list.f ====
common/link_pkg.sv
source/reset_sequencer.sv
source/traffic_gen.sv
source/traffic_check.sv
phy/phy_fifo.sv
phy/phy_link.sv
phy/phy_top.sv
source/link_test_top.sv
bench/link_test_props.sv
bench/link_test_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := link_test_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
